/* include/execute_defs.svh */
// widths fixed for the 32-bit scalar datapath; the ALU shifter assumes WORD_W is a power of two
`ifndef EXECUTE_DEFS_SVH
`define EXECUTE_DEFS_SVH

// data and address width
`define WORD_W 32

// register file index, 32 architectural regs
`define REG_W 5

// fall-through pc step, no compressed instructions
`define INSTR_STEP 4

`endif

/* hdl/execute_pkg.sv */
// enum encodings must match the scoreboard decode; only word stores (sw) are supported
`include "execute_defs.svh"

package execute_pkg;

    typedef logic [`WORD_W-1:0] word_t;
    typedef logic [`REG_W-1:0]  reg_idx_t;

    // scalar alu ops
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } aluop_t;

    // conditional compare kinds
    typedef enum logic [2:0] {BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU} branch_t;

    typedef enum logic [1:0] {MEM_LW, MEM_LB, MEM_LBU, MEM_SW} mem_type_t;

    // unit done flags, one bit per unit
    typedef logic [2:0] fu_ex_t;

    localparam int FU_ALU = 0;
    localparam int FU_LS  = 1;
    localparam int FU_BR  = 2;

    // j_type codes from decode
    localparam logic [1:0] J_COND = 2'd0;
    localparam logic [1:0] J_JAL  = 2'd1;
    localparam logic [1:0] J_JALR = 2'd2;

endpackage

/* hdl/fu_alu.sv */
// combinational only, no enable; flags are valid every cycle and overflow means something for add/sub only
`timescale 1ns/10ps
`include "execute_defs.svh"

module fu_alu (
    input  execute_pkg::aluop_t aluop,
    input  execute_pkg::word_t  port_a,
    input  execute_pkg::word_t  port_b,
    output execute_pkg::word_t  port_output,
    output logic                zero,
    output logic                negative,
    output logic                overflow
);
    import execute_pkg::*;

    localparam int MSB  = `WORD_W - 1;       // sign bit
    localparam int SH_W = $clog2(`WORD_W);   // 5 for 32-bit words

    word_t           sum;
    word_t           diff;
    logic [SH_W-1:0] shamt;

    assign shamt = port_b[SH_W-1:0];  // upper bits of b ignored
    assign sum   = port_a + port_b;
    assign diff  = port_a - port_b;

    always_comb begin
        port_output = '0;
        overflow    = 1'b0;
        case (aluop)
            ALU_ADD: begin
                port_output = sum;
                // same signs in, different sign out
                overflow = (port_a[MSB] == port_b[MSB]) && (sum[MSB] != port_a[MSB]);
            end
            ALU_SUB: begin
                port_output = diff;
                overflow = (port_a[MSB] != port_b[MSB]) && (diff[MSB] != port_a[MSB]);
            end
            ALU_AND:  port_output = port_a & port_b;
            ALU_OR:   port_output = port_a | port_b;
            ALU_XOR:  port_output = port_a ^ port_b;
            ALU_SLL:  port_output = port_a << shamt;
            ALU_SRL:  port_output = port_a >> shamt;
            ALU_SRA:  port_output = $signed(port_a) >>> shamt;  // keeps sign
            ALU_SLT:  port_output = {{MSB{1'b0}}, $signed(port_a) < $signed(port_b)};
            ALU_SLTU: port_output = {{MSB{1'b0}}, port_a < port_b};
            default:  port_output = '0;  // unused encodings
        endcase
    end

    // flags follow the result, not the inputs
    assign zero     = (port_output == '0);
    assign negative = port_output[MSB];

endmodule

/* hdl/fu_branch.sv */
// one-cycle registered resolve; j_type 3 is treated as a conditional branch, redirect outputs are pulses
`timescale 1ns/10ps
`include "execute_defs.svh"

module fu_branch (
    input  logic                  CLK,
    input  logic                  arst_n,
    input  logic                  enable,
    input  execute_pkg::branch_t  branch_type,
    input  logic [1:0]            j_type,
    input  execute_pkg::word_t    reg_a,
    input  execute_pkg::word_t    reg_b,
    input  execute_pkg::word_t    current_pc,
    input  execute_pkg::word_t    imm,
    input  logic                  predicted_outcome,
    input  execute_pkg::reg_idx_t rd,
    output logic                  resolved,
    output logic                  miss,
    output logic                  branch_outcome,
    output logic                  update_pc,
    output logic                  update_btb,
    output logic                  br_jump,
    output execute_pkg::word_t    branch_target,
    output execute_pkg::word_t    correct_pc,
    output execute_pkg::word_t    jump_wdat,
    output execute_pkg::reg_idx_t jump_rd
);
    import execute_pkg::*;

    logic  cmp_taken;
    logic  is_jump;
    logic  taken;
    logic  mispredict;
    word_t jalr_sum;
    word_t target;
    word_t fall_through;

    always_comb begin
        case (branch_type)
            BR_BEQ:  cmp_taken = (reg_a == reg_b);
            BR_BNE:  cmp_taken = (reg_a != reg_b);
            BR_BLT:  cmp_taken = ($signed(reg_a) < $signed(reg_b));
            BR_BGE:  cmp_taken = ($signed(reg_a) >= $signed(reg_b));
            BR_BLTU: cmp_taken = (reg_a < reg_b);
            BR_BGEU: cmp_taken = (reg_a >= reg_b);
            default: cmp_taken = 1'b0;  // bad encoding never taken
        endcase
    end

    assign is_jump      = (j_type == J_JAL) || (j_type == J_JALR);
    assign taken        = is_jump || cmp_taken;    // jumps always taken
    assign mispredict   = (taken != predicted_outcome);
    assign fall_through = current_pc + `INSTR_STEP;
    assign jalr_sum     = reg_a + imm;
    // jalr drops bit 0 of the sum
    assign target = (j_type == J_JALR) ? {jalr_sum[`WORD_W-1:1], 1'b0} : current_pc + imm;

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            resolved       <= 1'b0;
            miss           <= 1'b0;
            branch_outcome <= 1'b0;
            br_jump        <= 1'b0;
        end else begin
            resolved       <= enable;               // one pulse per issue
            miss           <= enable && mispredict;
            branch_outcome <= enable && taken;
            br_jump        <= enable && is_jump;    // link write next stage
        end
    end

    // redirect payload, only meaningful while the pulses are high
    always_ff @(posedge CLK) begin
        if (enable) begin
            branch_target <= target;
            correct_pc    <= taken ? target : fall_through;
            jump_wdat     <= fall_through;  // link value
            jump_rd       <= rd;
        end
    end

    assign update_pc  = miss;            // fetch redirects only on a miss
    assign update_btb = branch_outcome;  // btb learns taken branches

endmodule

/* hdl/fu_scalar_ls.sv */
// one outstanding request; enable while busy is ignored, stores are full words, loads are little-endian
`timescale 1ns/10ps
`include "execute_defs.svh"

module fu_scalar_ls (
    input  logic                    CLK,
    input  logic                    arst_n,
    input  logic                    enable,
    input  execute_pkg::mem_type_t  mem_type,
    input  execute_pkg::word_t      rs1,
    input  execute_pkg::word_t      rs2,
    input  execute_pkg::word_t      imm,
    input  execute_pkg::reg_idx_t   rd_in,
    input  execute_pkg::word_t      dmem_in,
    input  logic                    dhit_in,
    output execute_pkg::word_t      dmem_addr,
    output execute_pkg::word_t      dmem_store,
    output execute_pkg::word_t      dmem_load,
    output logic                    dmem_ren,
    output logic                    dmem_wen,
    output logic                    busy,
    output logic                    done,
    output logic                    is_load,
    output execute_pkg::reg_idx_t   rd
);
    import execute_pkg::*;

    mem_type_t req_type;   // latched type of the pending access
    logic      accept;
    logic      hit;
    logic      req_is_load;
    word_t     lane_word;
    logic [7:0] lane;
    word_t     load_ext;

    assign accept      = enable && !busy;
    assign hit         = busy && dhit_in;    // hit only counts with a request out
    assign req_is_load = (req_type != MEM_SW);

    // request levels held until the hit
    assign dmem_ren = busy && req_is_load;
    assign dmem_wen = busy && !req_is_load;

    // pick the addressed byte, byte 0 in bits 7:0
    assign lane_word = dmem_in >> {dmem_addr[1:0], 3'b000};
    assign lane      = lane_word[7:0];

    always_comb begin
        case (req_type)
            MEM_LB:  load_ext = {{(`WORD_W-8){lane[7]}}, lane};  // sign extend
            MEM_LBU: load_ext = {{(`WORD_W-8){1'b0}}, lane};
            default: load_ext = dmem_in;                          // lw, sw don't care
        endcase
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            busy    <= 1'b0;
            done    <= 1'b0;
            is_load <= 1'b0;
        end else begin
            done    <= hit;                  // one cycle after dhit
            is_load <= hit && req_is_load;
            if (accept) begin
                busy <= 1'b1;
            end else if (hit) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            dmem_addr  <= rs1 + imm;  // byte address
            dmem_store <= rs2;
            req_type   <= mem_type;
            rd         <= rd_in;
        end
        if (hit) begin
            dmem_load <= load_ext;
        end
    end

endmodule

/* hdl/ex_writeback.sv */
// single write port, no back-pressure; simultaneous results resolve load > jump link > alu, the loser is lost
`timescale 1ns/10ps

module ex_writeback (
    input  logic                  CLK,
    input  logic                  arst_n,
    input  logic                  alu_enable,
    input  execute_pkg::word_t    alu_result,
    input  execute_pkg::reg_idx_t alu_rd,
    input  logic                  br_jump,
    input  execute_pkg::word_t    jump_wdat,
    input  execute_pkg::reg_idx_t jump_rd,
    input  logic                  ls_done,
    input  logic                  ls_is_load,
    input  execute_pkg::word_t    ls_data,
    input  execute_pkg::reg_idx_t ls_rd,
    input  logic                  br_resolved,
    output logic                  wb_valid,
    output execute_pkg::reg_idx_t wb_rd,
    output execute_pkg::word_t    wb_data,
    output execute_pkg::fu_ex_t   fu_ex
);
    import execute_pkg::*;

    logic     load_wr;
    logic     any_wr;
    reg_idx_t next_rd;
    word_t    next_data;
    fu_ex_t   next_ex;

    assign load_wr = ls_done && ls_is_load;  // stores finish without a write
    assign any_wr  = load_wr || br_jump || alu_enable;

    // fixed priority mux
    always_comb begin
        if (load_wr) begin
            next_rd   = ls_rd;
            next_data = ls_data;
        end else if (br_jump) begin
            next_rd   = jump_rd;
            next_data = jump_wdat;
        end else begin
            next_rd   = alu_rd;
            next_data = alu_result;
        end
    end

    always_comb begin
        next_ex         = '0;
        next_ex[FU_ALU] = alu_enable;
        next_ex[FU_LS]  = ls_done;      // loads and stores
        next_ex[FU_BR]  = br_resolved;  // every branch, taken or not
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
            fu_ex    <= '0;
        end else begin
            wb_valid <= any_wr && (next_rd != '0);  // x0 never written
            fu_ex    <= next_ex;
        end
    end

    always_ff @(posedge CLK) begin
        if (any_wr) begin
            wb_rd   <= next_rd;
            wb_data <= next_data;
        end
    end

endmodule

/* hdl/execute.sv */
// scalar execute only; issuer must keep enables one-hot and space ops so writebacks never collide
`timescale 1ns/10ps

module execute (
    input  logic                   CLK,
    input  logic                   arst_n,
    // scalar alu issue
    input  logic                   salu_enable,
    input  execute_pkg::aluop_t    salu_aluop,
    input  execute_pkg::word_t     salu_port_a,
    input  execute_pkg::word_t     salu_port_b,
    // branch issue
    input  logic                   bfu_enable,
    input  execute_pkg::branch_t   bfu_branch_type,
    input  logic [1:0]             bfu_j_type,
    input  execute_pkg::word_t     bfu_reg_a,
    input  execute_pkg::word_t     bfu_reg_b,
    input  execute_pkg::word_t     bfu_current_pc,
    input  execute_pkg::word_t     bfu_imm,
    input  logic                   bfu_predicted_outcome,
    // load/store issue
    input  logic                   sls_enable,
    input  execute_pkg::mem_type_t sls_mem_type,
    input  execute_pkg::word_t     sls_rs1,
    input  execute_pkg::word_t     sls_rs2,
    input  execute_pkg::word_t     sls_imm,
    input  execute_pkg::reg_idx_t  rd,               // dest of the enabled unit
    // data memory
    input  execute_pkg::word_t     sls_dmem_in,
    input  logic                   sls_dhit_in,
    output execute_pkg::word_t     sls_dmem_addr,
    output logic                   sls_dmem_ren,
    output logic                   sls_dmem_wen,
    output execute_pkg::word_t     sls_dmem_store,
    output logic                   sls_busy,
    // alu flags, combinational
    output logic                   salu_zero,
    output logic                   salu_negative,
    output logic                   salu_overflow,
    // redirect to fetch
    output logic                   bfu_resolved,
    output logic                   bfu_miss,
    output logic                   bfu_branch_outcome,
    output logic                   bfu_update_pc,
    output logic                   bfu_update_btb,
    output execute_pkg::word_t     bfu_branch_target,
    output execute_pkg::word_t     bfu_correct_pc,
    // register write and done flags
    output logic                   wb_valid,
    output execute_pkg::reg_idx_t  wb_rd,
    output execute_pkg::word_t     wb_data,
    output execute_pkg::fu_ex_t    fu_ex
);
    import execute_pkg::*;

    word_t    salu_result;
    logic     br_jump;
    word_t    jump_wdat;
    reg_idx_t jump_rd;
    word_t    sls_dmem_load;
    logic     sls_done;
    logic     sls_is_load;
    reg_idx_t sls_rd;

    fu_alu u_alu (
        .aluop       (salu_aluop),
        .port_a      (salu_port_a),
        .port_b      (salu_port_b),
        .port_output (salu_result),
        .zero        (salu_zero),
        .negative    (salu_negative),
        .overflow    (salu_overflow)
    );

    fu_branch u_branch (
        .CLK               (CLK),
        .arst_n            (arst_n),
        .enable            (bfu_enable),
        .branch_type       (bfu_branch_type),
        .j_type            (bfu_j_type),
        .reg_a             (bfu_reg_a),
        .reg_b             (bfu_reg_b),
        .current_pc        (bfu_current_pc),
        .imm               (bfu_imm),
        .predicted_outcome (bfu_predicted_outcome),
        .rd                (rd),
        .resolved          (bfu_resolved),
        .miss              (bfu_miss),
        .branch_outcome    (bfu_branch_outcome),
        .update_pc         (bfu_update_pc),
        .update_btb        (bfu_update_btb),
        .br_jump           (br_jump),
        .branch_target     (bfu_branch_target),
        .correct_pc        (bfu_correct_pc),
        .jump_wdat         (jump_wdat),
        .jump_rd           (jump_rd)
    );

    fu_scalar_ls u_sls (
        .CLK        (CLK),
        .arst_n     (arst_n),
        .enable     (sls_enable),
        .mem_type   (sls_mem_type),
        .rs1        (sls_rs1),
        .rs2        (sls_rs2),
        .imm        (sls_imm),
        .rd_in      (rd),
        .dmem_in    (sls_dmem_in),
        .dhit_in    (sls_dhit_in),
        .dmem_addr  (sls_dmem_addr),
        .dmem_store (sls_dmem_store),
        .dmem_load  (sls_dmem_load),
        .dmem_ren   (sls_dmem_ren),
        .dmem_wen   (sls_dmem_wen),
        .busy       (sls_busy),
        .done       (sls_done),
        .is_load    (sls_is_load),
        .rd         (sls_rd)
    );

    // alu result registered here, one cycle after issue
    ex_writeback u_wb (
        .CLK         (CLK),
        .arst_n      (arst_n),
        .alu_enable  (salu_enable),
        .alu_result  (salu_result),
        .alu_rd      (rd),
        .br_jump     (br_jump),
        .jump_wdat   (jump_wdat),
        .jump_rd     (jump_rd),
        .ls_done     (sls_done),
        .ls_is_load  (sls_is_load),
        .ls_data     (sls_dmem_load),
        .ls_rd       (sls_rd),
        .br_resolved (bfu_resolved),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .fu_ex       (fu_ex)
    );

endmodule

/* bench/execute_props.sv */
// assumes the scoreboard issue contract; rules are checked only while arst_n is high
`timescale 1ns/10ps

module execute_props (
    input logic                CLK,
    input logic                arst_n,
    input logic                salu_enable,
    input logic                bfu_enable,
    input logic                sls_enable,
    input logic                sls_busy,
    input execute_pkg::fu_ex_t fu_ex
);

    // one unit per issue slot
    a_issue_onehot: assert property (@(posedge CLK) disable iff (!arst_n)
        $onehot0({salu_enable, bfu_enable, sls_enable}))
        else $error("more than one unit enabled in the same cycle");

    a_busy_issue: assert property (@(posedge CLK) disable iff (!arst_n)
        sls_enable |-> !sls_busy)
        else $error("load/store issued while the unit was busy");

    // issuer spacing keeps completions apart
    a_single_wb: assert property (@(posedge CLK) disable iff (!arst_n)
        $onehot0(fu_ex))
        else $error("two units completed in the same cycle");

endmodule

bind execute execute_props u_props (
    .CLK          (CLK),
    .arst_n       (arst_n),
    .salu_enable  (salu_enable),
    .bfu_enable   (bfu_enable),
    .sls_enable   (sls_enable),
    .sls_busy     (sls_busy),
    .fu_ex        (fu_ex)
);

/* bench/execute_tb.sv */
// inputs driven on rising edges, outputs sampled on falling edges; memory model covers 64 words only
`timescale 1ns/10ps
`include "execute_defs.svh"

module execute_tb;
    import execute_pkg::*;

    localparam int N_OPS       = 32;  // alu 11, branch 14, memory 6, x0 1
    localparam int WORST_CYC   = 8;   // load with four wait cycles plus writeback
    localparam int TIMEOUT_CYC = 2 * N_OPS * WORST_CYC;
    localparam logic [5:0] TAKEN = 6'b100110;  // per branch_t for a=-1, b=1

    logic CLK;
    logic arst_n;
    logic salu_enable, bfu_enable, sls_enable;
    aluop_t salu_aluop;
    word_t salu_port_a, salu_port_b;
    branch_t bfu_branch_type;
    logic [1:0] bfu_j_type;
    word_t bfu_reg_a, bfu_reg_b, bfu_current_pc, bfu_imm;
    logic bfu_predicted_outcome;
    mem_type_t sls_mem_type;
    word_t sls_rs1, sls_rs2, sls_imm, sls_dmem_in;
    reg_idx_t rd;
    logic sls_dhit_in;
    word_t sls_dmem_addr, sls_dmem_store;
    logic sls_dmem_ren, sls_dmem_wen, sls_busy;
    logic salu_zero, salu_negative, salu_overflow;
    logic bfu_resolved, bfu_miss, bfu_branch_outcome, bfu_update_pc, bfu_update_btb;
    word_t bfu_branch_target, bfu_correct_pc;
    logic wb_valid;
    reg_idx_t wb_rd;
    word_t wb_data;
    fu_ex_t fu_ex;

    word_t mem [64];       // word indexed data memory model
    int mismatch_errs = 0;
    int other_errs    = 0;

    execute u_execute (.*);

    always #10 CLK = ~CLK;  // 20 ns period

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            mismatch_errs++;
            $display("mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            mismatch_errs++;
            $display("mismatch %s: got 0x%02h expected 0x%02h", name, got, exp);
        end
    endtask

    task automatic check_flags(input logic z, input logic n, input logic v,
                               input logic [2:0] exp);
        if ({z, n, v} !== exp) begin
            mismatch_errs++;
            $display("mismatch salu_flags(z,n,v): got 0x%0h expected 0x%0h", {z, n, v}, exp);
        end
    endtask

    task automatic check_fu_ex(input fu_ex_t got, input fu_ex_t exp);
        if (got !== exp) begin
            mismatch_errs++;
            $display("mismatch fu_ex: got 0x%0h expected 0x%0h", got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_errs++;
            $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
        if (mismatch_errs == 0 && other_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    task automatic run_alu(input aluop_t op, input word_t a, input word_t b,
                           input reg_idx_t dst, input word_t exp, input logic [2:0] exp_zny);
        @(posedge CLK);
        salu_enable <= 1'b1;
        salu_aluop  <= op;
        salu_port_a <= a;
        salu_port_b <= b;
        rd          <= dst;
        @(posedge CLK);
        salu_enable <= 1'b0;  // operands held so flags stay valid
        @(negedge CLK);
        check_bit("wb_valid", wb_valid, dst != '0);
        if (dst != '0) begin
            check_idx("wb_rd", wb_rd, dst);
            check_word("wb_data", wb_data, exp);
        end
        check_flags(salu_zero, salu_negative, salu_overflow, exp_zny);
        check_fu_ex(fu_ex, 3'b001);
    endtask

    task automatic run_branch(input branch_t bt, input logic [1:0] jt, input word_t a,
                              input word_t b, input word_t pc, input word_t imm,
                              input logic pred, input reg_idx_t dst, input logic exp_taken,
                              input word_t exp_target);
        logic is_jump;
        logic exp_miss;
        is_jump  = (jt == J_JAL) || (jt == J_JALR);
        exp_miss = (exp_taken != pred);
        @(posedge CLK);
        bfu_enable            <= 1'b1;
        bfu_branch_type       <= bt;
        bfu_j_type            <= jt;
        bfu_reg_a             <= a;
        bfu_reg_b             <= b;
        bfu_current_pc        <= pc;
        bfu_imm               <= imm;
        bfu_predicted_outcome <= pred;
        rd                    <= dst;
        @(posedge CLK);
        bfu_enable <= 1'b0;
        @(negedge CLK);  // redirect pulse cycle
        check_bit("bfu_resolved", bfu_resolved, 1'b1);
        check_bit("bfu_miss", bfu_miss, exp_miss);
        check_bit("bfu_branch_outcome", bfu_branch_outcome, exp_taken);
        check_bit("bfu_update_pc", bfu_update_pc, exp_miss);
        check_bit("bfu_update_btb", bfu_update_btb, exp_taken);
        check_word("bfu_branch_target", bfu_branch_target, exp_target);
        check_word("bfu_correct_pc", bfu_correct_pc,
                   exp_taken ? exp_target : pc + `INSTR_STEP);
        check_bit("wb_valid", wb_valid, 1'b0);
        @(negedge CLK);  // link write cycle
        check_bit("bfu_resolved", bfu_resolved, 1'b0);
        check_fu_ex(fu_ex, 3'b100);
        check_bit("wb_valid", wb_valid, is_jump && dst != '0);
        if (is_jump && dst != '0) begin
            check_idx("wb_rd", wb_rd, dst);
            check_word("wb_data", wb_data, pc + `INSTR_STEP);
        end
    endtask

    task automatic run_mem(input mem_type_t mt, input word_t base, input word_t data,
                           input word_t off, input reg_idx_t dst, input word_t exp);
        logic is_ld;
        logic got_hit;
        int   waited;
        is_ld   = (mt != MEM_SW);
        got_hit = 1'b0;
        waited  = 0;
        @(posedge CLK);
        sls_enable   <= 1'b1;
        sls_mem_type <= mt;
        sls_rs1      <= base;
        sls_rs2      <= data;
        sls_imm      <= off;
        rd           <= dst;
        @(posedge CLK);
        sls_enable <= 1'b0;
        while (!got_hit && waited < WORST_CYC) begin  // request held until the hit
            @(negedge CLK);
            check_bit("sls_busy", sls_busy, 1'b1);
            check_bit("sls_dmem_ren", sls_dmem_ren, is_ld);
            check_bit("sls_dmem_wen", sls_dmem_wen, !is_ld);
            check_word("sls_dmem_addr", sls_dmem_addr, base + off);
            if (!is_ld) check_word("sls_dmem_store", sls_dmem_store, data);
            got_hit = sls_dhit_in;
            waited++;
        end
        if (!got_hit) begin
            other_errs++;
            $display("data memory never answered the request at 0x%08h", base + off);
        end
        @(negedge CLK);  // done pulse cycle
        check_bit("sls_busy", sls_busy, 1'b0);
        check_bit("sls_dmem_ren", sls_dmem_ren, 1'b0);
        check_bit("sls_dmem_wen", sls_dmem_wen, 1'b0);
        @(negedge CLK);
        check_fu_ex(fu_ex, 3'b010);
        check_bit("wb_valid", wb_valid, is_ld && dst != '0);
        if (is_ld && dst != '0) begin
            check_idx("wb_rd", wb_rd, dst);
            check_word("wb_data", wb_data, exp);
        end
    endtask

    task automatic test_reset_state();
        @(negedge CLK);
        check_bit("wb_valid", wb_valid, 1'b0);
        check_fu_ex(fu_ex, 3'b000);
        check_bit("bfu_resolved", bfu_resolved, 1'b0);
        check_bit("bfu_miss", bfu_miss, 1'b0);
        check_bit("bfu_update_pc", bfu_update_pc, 1'b0);
        check_bit("bfu_update_btb", bfu_update_btb, 1'b0);
        check_bit("sls_dmem_ren", sls_dmem_ren, 1'b0);
        check_bit("sls_dmem_wen", sls_dmem_wen, 1'b0);
        check_bit("sls_busy", sls_busy, 1'b0);
    endtask

    task automatic test_alu_ops();
        // flags column is {zero, negative, overflow}
        run_alu(ALU_ADD,  32'h7fff_ffff, 32'h0000_0001, 5'd1, 32'h8000_0000, 3'b011);
        run_alu(ALU_ADD,  32'hffff_ffff, 32'h0000_0001, 5'd2, 32'h0000_0000, 3'b100);
        run_alu(ALU_SUB,  32'h8000_0000, 32'h0000_0001, 5'd3, 32'h7fff_ffff, 3'b001);
        run_alu(ALU_AND,  32'hf0f0_f0f0, 32'h0ff0_0ff0, 5'd4, 32'h00f0_00f0, 3'b000);
        run_alu(ALU_OR,   32'h0000_0000, 32'h0000_0000, 5'd5, 32'h0000_0000, 3'b100);
        run_alu(ALU_XOR,  32'hffff_ffff, 32'h0000_ffff, 5'd6, 32'hffff_0000, 3'b010);
        run_alu(ALU_SLL,  32'h0000_0001, 32'h0000_0021, 5'd7, 32'h0000_0002, 3'b000);
        run_alu(ALU_SRL,  32'h8000_0000, 32'h0000_001f, 5'd8, 32'h0000_0001, 3'b000);
        run_alu(ALU_SRA,  32'h8000_0000, 32'h0000_0004, 5'd9, 32'hf800_0000, 3'b010);
        run_alu(ALU_SLT,  32'hffff_ffff, 32'h0000_0001, 5'd10, 32'h0000_0001, 3'b000);
        run_alu(ALU_SLTU, 32'hffff_ffff, 32'h0000_0001, 5'd11, 32'h0000_0000, 3'b100);
    endtask

    task automatic test_x0_write();
        run_alu(ALU_ADD, 32'h0000_0005, 32'h0000_0003, 5'd0, 32'h0000_0008, 3'b000);
    endtask

    task automatic test_cond_branches();
        for (int i = 0; i < 6; i++) begin
            for (int p = 0; p < 2; p++) begin
                run_branch(branch_t'(i), J_COND, 32'hffff_ffff, 32'h0000_0001,
                           32'h0000_1000, 32'h0000_0040, p[0], 5'd7, TAKEN[i], 32'h0000_1040);
            end
        end
    endtask

    task automatic test_jumps();
        run_branch(BR_BEQ, J_JAL, 32'h0, 32'h0, 32'h0000_2000, 32'h0000_0100, 1'b1, 5'd5,
                   1'b1, 32'h0000_2100);
        // odd sum loses bit 0
        run_branch(BR_BEQ, J_JALR, 32'h0000_3001, 32'h0, 32'h0000_2000, 32'h0000_0010, 1'b0,
                   5'd6, 1'b1, 32'h0000_3010);
    endtask

    task automatic test_load_store();
        run_mem(MEM_SW,  32'h20, 32'h80ff_7f12, 32'h4, 5'd10, 32'h0);
        run_mem(MEM_LW,  32'h20, 32'h0, 32'h4, 5'd11, 32'h80ff_7f12);
        run_mem(MEM_LB,  32'h20, 32'h0, 32'h5, 5'd12, 32'h0000_007f);
        run_mem(MEM_LB,  32'h20, 32'h0, 32'h7, 5'd13, 32'hffff_ff80);
        run_mem(MEM_LBU, 32'h20, 32'h0, 32'h6, 5'd14, 32'h0000_00ff);
        run_mem(MEM_LB,  32'h20, 32'h0, 32'h6, 5'd15, 32'hffff_ffff);
    endtask

    // memory model answers after 1 to 4 cycles
    initial begin : mem_model
        int lat;
        void'($urandom(32'h6f13_58a4));
        for (int i = 0; i < 64; i++) begin
            mem[i] = 32'hc3a5_0000 ^ (i * 32'h0101_0107);  // pattern over the whole index
        end
        sls_dhit_in = 1'b0;
        sls_dmem_in = '0;
        forever begin
            @(negedge CLK);
            if (sls_dmem_ren || sls_dmem_wen) begin
                lat = 1 + int'($urandom % 4);
                repeat (lat - 1) @(negedge CLK);
                @(posedge CLK);
                sls_dhit_in <= 1'b1;
                sls_dmem_in <= mem[sls_dmem_addr[7:2]];
                if (sls_dmem_wen) mem[sls_dmem_addr[7:2]] <= sls_dmem_store;
                @(posedge CLK);
                sls_dhit_in <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYC) @(posedge CLK);
        other_errs++;
        $display("timeout after %0d cycles, tests did not finish", TIMEOUT_CYC);
        finish_run();
    end

    initial begin
        CLK                   = 1'b0;
        arst_n                = 1'b0;
        salu_enable           = 1'b0;
        salu_aluop            = ALU_ADD;
        salu_port_a           = '0;
        salu_port_b           = '0;
        bfu_enable            = 1'b0;
        bfu_branch_type       = BR_BEQ;
        bfu_j_type            = J_COND;
        bfu_reg_a             = '0;
        bfu_reg_b             = '0;
        bfu_current_pc        = '0;
        bfu_imm               = '0;
        bfu_predicted_outcome = 1'b0;
        sls_enable            = 1'b0;
        sls_mem_type          = MEM_LW;
        sls_rs1               = '0;
        sls_rs2               = '0;
        sls_imm               = '0;
        rd                    = '0;
        repeat (8) @(posedge CLK);
        arst_n <= 1'b1;
        test_reset_state();
        test_alu_ops();
        test_x0_write();
        test_cond_branches();
        test_jumps();
        test_load_store();
        repeat (2) @(posedge CLK);
        finish_run();
    end

endmodule

/* list.f */
+incdir+include
hdl/execute_pkg.sv
hdl/fu_alu.sv
hdl/fu_branch.sv
hdl/fu_scalar_ls.sv
hdl/ex_writeback.sv
hdl/execute.sv
bench/execute_props.sv
bench/execute_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build with Verilator, run, and decide from the simulation output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f list.f --top-module execute_tb -o execute_sim \
    && ./obj_dir/execute_sim | tee /dev/stderr | grep -x "Result: PASSED" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
